// File: up_pkg.sv
package up_pkg;

   // machine widths
   localparam int DATA_W    = 8;
   localparam int NIBBLE_W  = 4;
   localparam int NUM_REGS  = 4;
   localparam int REG_SEL_W = $clog2(NUM_REGS);

   typedef logic [DATA_W-1:0]    data_t;
   typedef logic [NIBBLE_W-1:0]  nibble_t;
   typedef logic [REG_SEL_W-1:0] reg_sel_t;

   // alu operations, encoding matches the a_op port
   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_XOR    = 3'd4,
      ALU_NOT    = 3'd5,
      ALU_PASS_A = 3'd6,
      ALU_PASS_B = 3'd7
   } alu_op_t;

   // program counter operations
   typedef enum logic [1:0] {
      PC_HOLD  = 2'd0,
      PC_INC   = 2'd1,
      PC_LOAD  = 2'd2,
      PC_CLEAR = 2'd3
   } pc_op_t;

   // stack grows down from the top of memory
   localparam data_t SP_RESET = 8'hFF;
   localparam data_t PC_RESET = 8'h00;

endpackage

// File: up_rb_if.sv
`timescale 1ns/1ps

interface up_rb_if import up_pkg::*;;

   // register reads toward the alu
   data_t read_a;
   data_t read_b;

   // alu write-back toward the registers
   data_t result_a;
   data_t result_b;

   modport rb (
      output read_a,
      output read_b,
      input  result_a,
      input  result_b
   );

   modport alu (
      input  read_a,
      input  read_b,
      output result_a,
      output result_b
   );

endinterface

// File: up_alu.sv
`timescale 1ns/1ps

module up_alu import up_pkg::*; (
   up_rb_if.alu   ops,
   input  data_t   sp,
   input  data_t   pc,
   input  logic    sel_in_a,
   input  logic    sel_in_b,
   input  alu_op_t op,
   output data_t   data_out
);

   data_t opnd_a;
   data_t opnd_b;
   data_t result;

   // operand a is a register or the stack pointer
   assign opnd_a = sel_in_a ? sp : ops.read_a;

   // pc counts nibbles, so shift down to get the word address
   assign opnd_b = sel_in_b ? (pc >> 1) : ops.read_b;

   always_comb begin
      case (op)
         ALU_ADD: begin
            result = opnd_a + opnd_b;
         end
         ALU_SUB: begin
            result = opnd_a - opnd_b;
         end
         ALU_AND: begin
            result = opnd_a & opnd_b;
         end
         ALU_OR: begin
            result = opnd_a | opnd_b;
         end
         ALU_XOR: begin
            result = opnd_a ^ opnd_b;
         end
         ALU_NOT: begin
            result = ~opnd_a;
         end
         ALU_PASS_A: begin
            result = opnd_a;
         end
         ALU_PASS_B: begin
            result = opnd_b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

   assign data_out     = result;
   assign ops.result_a = result;

   // port b write-back gets operand a, used for moves and sp saves
   assign ops.result_b = opnd_a;

endmodule

// File: up_reg_block.sv
`timescale 1ns/1ps

module up_reg_block import up_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   up_rb_if.rb      ops,
   input  data_t    data_in,
   input  logic     src_alu,
   input  reg_sel_t sel_out_a,
   input  reg_sel_t sel_out_b,
   input  reg_sel_t sel_write_a,
   input  reg_sel_t sel_write_b,
   input  logic     we_a,
   input  logic     we_b
);

   data_t regs [NUM_REGS];
   data_t wr_data_a;
   data_t wr_data_b;

   // port a writes either the alu result or external data
   assign wr_data_a = src_alu ? ops.result_a : data_in;
   assign wr_data_b = ops.result_b;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (we_a) begin
            regs[sel_write_a] <= wr_data_a;
         end
         // port b goes last so it wins on a collision
         if (we_b) begin
            regs[sel_write_b] <= wr_data_b;
         end
      end
   end

   // asynchronous reads
   assign ops.read_a = regs[sel_out_a];
   assign ops.read_b = regs[sel_out_b];

endmodule

// File: up_program_counter.sv
`timescale 1ns/1ps

module up_program_counter import up_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  pc_op_t op,
   input  data_t  data_in,
   output data_t  pc
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= PC_RESET;
      end else begin
         case (op)
            PC_INC: begin
               // wraps at 256
               pc <= pc + 8'd1;
            end
            PC_LOAD: begin
               pc <= data_in;
            end
            PC_CLEAR: begin
               pc <= PC_RESET;
            end
            default: begin
               pc <= pc;
            end
         endcase
      end
   end

endmodule

// File: up_instruction_register.sv
`timescale 1ns/1ps

module up_instruction_register import up_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    we,
   input  logic    sel,
   input  data_t   data_in,
   output nibble_t ir
);

   data_t ir_byte;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ir_byte <= '0;
      end else if (we) begin
         ir_byte <= data_in;
      end
   end

   // two opcodes per byte, high nibble first
   assign ir = sel ? ir_byte[NIBBLE_W-1:0] : ir_byte[DATA_W-1:NIBBLE_W];

endmodule

// File: up_stack_pointer.sv
`timescale 1ns/1ps

module up_stack_pointer import up_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  add,
   input  logic  sub,
   output data_t sp
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sp <= SP_RESET;
      end else begin
         case ({add, sub})
            2'b10: begin
               sp <= sp + 8'd1;
            end
            2'b01: begin
               sp <= sp - 8'd1;
            end
            // both or neither means hold
            default: begin
               sp <= sp;
            end
         endcase
      end
   end

endmodule

// File: up_datapath.sv
`timescale 1ns/1ps

module up_datapath import up_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  data_t      data_in,
   // alu
   input  logic       a_sel_in_a,
   input  logic       a_sel_in_b,
   input  logic [2:0] a_op,
   // instruction register
   input  logic       ir_we,
   // program counter
   input  logic [1:0] pc_op,
   // register block
   input  reg_sel_t   rb_sel_out_a,
   input  reg_sel_t   rb_sel_out_b,
   input  reg_sel_t   rb_sel_write_a,
   input  reg_sel_t   rb_sel_write_b,
   input  logic       rb_we_a,
   input  logic       rb_we_b,
   input  logic       rb_src_alu,
   // stack pointer
   input  logic       sp_add,
   input  logic       sp_sub,
   output data_t      data_out,
   output nibble_t    ir
);

   data_t   pc;
   data_t   sp;
   alu_op_t alu_op;
   pc_op_t  pc_cmd;

   assign alu_op = alu_op_t'(a_op);
   assign pc_cmd = pc_op_t'(pc_op);

   up_rb_if rb_bus ();

   up_alu up_alu (
      .ops         (rb_bus.alu),
      .sp          (sp),
      .pc          (pc),
      .sel_in_a    (a_sel_in_a),
      .sel_in_b    (a_sel_in_b),
      .op          (alu_op),
      .data_out    (data_out)
   );

   up_reg_block up_reg_block (
      .clk         (clk),
      .rst_n       (rst_n),
      .ops         (rb_bus.rb),
      .data_in     (data_in),
      .src_alu     (rb_src_alu),
      .sel_out_a   (rb_sel_out_a),
      .sel_out_b   (rb_sel_out_b),
      .sel_write_a (rb_sel_write_a),
      .sel_write_b (rb_sel_write_b),
      .we_a        (rb_we_a),
      .we_b        (rb_we_b)
   );

   up_program_counter up_program_counter (
      .clk         (clk),
      .rst_n       (rst_n),
      .op          (pc_cmd),
      .data_in     (data_in),
      .pc          (pc)
   );

   // pc bit 0 picks the nibble
   up_instruction_register up_instruction_register (
      .clk         (clk),
      .rst_n       (rst_n),
      .we          (ir_we),
      .sel         (pc[0]),
      .data_in     (data_in),
      .ir          (ir)
   );

   up_stack_pointer up_stack_pointer (
      .clk         (clk),
      .rst_n       (rst_n),
      .add         (sp_add),
      .sub         (sp_sub),
      .sp          (sp)
   );

endmodule

// File: up_datapath_tb.sv
`timescale 1ns/1ps

module up_datapath_tb;

   localparam int MAX_VECS = 256;
   localparam int NUM_COLS = 18;

   logic       clk;
   logic       rst_n;
   logic [7:0] data_in;
   logic       a_sel_in_a;
   logic       a_sel_in_b;
   logic [2:0] a_op;
   logic       ir_we;
   logic [1:0] pc_op;
   logic [1:0] rb_sel_out_a;
   logic [1:0] rb_sel_out_b;
   logic [1:0] rb_sel_write_a;
   logic [1:0] rb_sel_write_b;
   logic       rb_we_a;
   logic       rb_we_b;
   logic       rb_src_alu;
   logic       sp_add;
   logic       sp_sub;
   logic [7:0] data_out;
   logic [3:0] ir;

   int vec [0:MAX_VECS-1][0:NUM_COLS-1];
   int num_vecs;
   int cycles;
   int cycle_limit;
   int tests_passed;
   int tests_failed;
   int test_errors;
   int cur_test;
   bit load_ok;

   up_datapath dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .data_in        (data_in),
      .a_sel_in_a     (a_sel_in_a),
      .a_sel_in_b     (a_sel_in_b),
      .a_op           (a_op),
      .ir_we          (ir_we),
      .pc_op          (pc_op),
      .rb_sel_out_a   (rb_sel_out_a),
      .rb_sel_out_b   (rb_sel_out_b),
      .rb_sel_write_a (rb_sel_write_a),
      .rb_sel_write_b (rb_sel_write_b),
      .rb_we_a        (rb_we_a),
      .rb_we_b        (rb_we_b),
      .rb_src_alu     (rb_src_alu),
      .sp_add         (sp_add),
      .sp_sub         (sp_sub),
      .data_out       (data_out),
      .ir             (ir)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // limit is zero until the vectors are known
   initial begin
      wait (cycle_limit > 0);
      while (cycles <= cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
   end

   task automatic load_vectors();
      int fd;
      int n;
      string line;
      fd = $fopen("up_datapath_input.txt", "r");
      if (fd == 0) begin
         $display("could not open data file up_datapath_input.txt");
         load_ok = 1'b0;
      end else begin
         while (!$feof(fd) && num_vecs < MAX_VECS) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
               break;
            end
            // skip blank and comment lines
            if (line.len() < 2 || line[0] == "#") begin
               continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vec[num_vecs][0], vec[num_vecs][1], vec[num_vecs][2],
                        vec[num_vecs][3], vec[num_vecs][4], vec[num_vecs][5],
                        vec[num_vecs][6], vec[num_vecs][7], vec[num_vecs][8],
                        vec[num_vecs][9], vec[num_vecs][10], vec[num_vecs][11],
                        vec[num_vecs][12], vec[num_vecs][13], vec[num_vecs][14],
                        vec[num_vecs][15], vec[num_vecs][16], vec[num_vecs][17]);
            if (n != NUM_COLS) begin
               $display("data file line %0d is short, found %0d of %0d fields",
                        num_vecs + 1, n, NUM_COLS);
               load_ok = 1'b0;
               break;
            end
            num_vecs++;
         end
         $fclose(fd);
         if (load_ok && num_vecs == 0) begin
            $display("data file up_datapath_input.txt holds no vectors");
            load_ok = 1'b0;
         end
      end
   endtask

   task automatic apply_vector(input int i);
      a_sel_in_a     = vec[i][1][0];
      a_sel_in_b     = vec[i][2][0];
      a_op           = vec[i][3][2:0];
      ir_we          = vec[i][4][0];
      pc_op          = vec[i][5][1:0];
      rb_sel_out_a   = vec[i][6][1:0];
      rb_sel_out_b   = vec[i][7][1:0];
      rb_sel_write_a = vec[i][8][1:0];
      rb_sel_write_b = vec[i][9][1:0];
      rb_we_a        = vec[i][10][0];
      rb_we_b        = vec[i][11][0];
      rb_src_alu     = vec[i][12][0];
      sp_add         = vec[i][13][0];
      sp_sub         = vec[i][14][0];
      data_in        = vec[i][15][7:0];
   endtask

   task automatic report_test(input int num);
      if (test_errors == 0) begin
         $display("test %0d passed", num);
         tests_passed++;
      end else begin
         $display("test %0d failed with %0d errors", num, test_errors);
         tests_failed++;
      end
      test_errors = 0;
   endtask

   initial begin
      rst_n          = 1'b0;
      data_in        = '0;
      a_sel_in_a     = 1'b0;
      a_sel_in_b     = 1'b0;
      a_op           = '0;
      ir_we          = 1'b0;
      pc_op          = '0;
      rb_sel_out_a   = '0;
      rb_sel_out_b   = '0;
      rb_sel_write_a = '0;
      rb_sel_write_b = '0;
      rb_we_a        = 1'b0;
      rb_we_b        = 1'b0;
      rb_src_alu     = 1'b0;
      sp_add         = 1'b0;
      sp_sub         = 1'b0;
      cycles         = 0;
      cycle_limit    = 0;
      num_vecs       = 0;
      tests_passed   = 0;
      tests_failed   = 0;
      test_errors    = 0;
      load_ok        = 1'b1;

      load_vectors();
      if (!load_ok) begin
         $display("Something failed");
         $finish;
      end else begin
         cycle_limit = num_vecs + 20;
         cur_test    = vec[0][0];

         repeat (3) @(posedge clk);
         @(negedge clk);
         rst_n = 1'b1;

         for (int i = 0; i < num_vecs; i++) begin
            if (vec[i][0] != cur_test) begin
               report_test(cur_test);
               cur_test = vec[i][0];
            end
            apply_vector(i);
            // sample just before the next rising edge
            #9;
            if (data_out !== vec[i][16][7:0]) begin
               $display("FAILED at %0t: data_out expected %h got %h (test %0d)",
                        $time, vec[i][16][7:0], data_out, cur_test);
               test_errors++;
            end
            if (ir !== vec[i][17][3:0]) begin
               $display("FAILED at %0t: ir expected %h got %h (test %0d)",
                        $time, vec[i][17][3:0], ir, cur_test);
               test_errors++;
            end
            @(negedge clk);
         end
         report_test(cur_test);

         $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
         if (tests_failed == 0) begin
            $display("Everything OK");
         end else begin
            $display("Something failed");
         end
         $finish;
      end
   end

endmodule

// File: up_datapath_input.txt
# test sel_a sel_b op ir_we pc_op out_a out_b wr_a wr_b we_a we_b src add sub
# data_in exp_data_out exp_ir, all hex
1 1 0 6 0 0 0 0 0 0 0 0 0 0 0 00 ff 0
1 0 1 7 0 0 0 0 0 0 0 0 0 0 0 00 00 0
2 0 0 6 0 0 0 0 0 0 1 0 0 0 0 3c 00 0
2 0 0 6 0 0 1 0 1 0 1 0 0 0 0 a5 00 0
2 0 0 6 0 0 2 0 2 0 1 0 0 0 0 0f 00 0
2 0 0 6 0 0 3 0 3 0 1 0 0 0 0 f0 00 0
2 0 0 0 0 0 0 1 0 0 0 0 0 0 0 00 e1 0
2 0 0 1 0 0 0 1 0 0 0 0 0 0 0 00 97 0
2 0 0 1 0 0 1 0 0 0 0 0 0 0 0 00 69 0
2 0 0 2 0 0 2 3 0 0 0 0 0 0 0 00 00 0
2 0 0 3 0 0 2 3 0 0 0 0 0 0 0 00 ff 0
2 0 0 4 0 0 0 1 0 0 0 0 0 0 0 00 99 0
2 0 0 5 0 0 1 0 0 0 0 0 0 0 0 00 5a 0
2 0 0 0 0 0 3 1 0 0 0 0 0 0 0 00 95 0
3 0 0 0 0 0 0 2 2 3 1 1 1 0 0 00 4b 0
3 0 0 6 0 0 2 0 0 0 0 0 0 0 0 00 4b 0
3 0 0 6 0 0 3 0 0 0 0 0 0 0 0 00 3c 0
3 0 0 7 0 0 1 0 0 0 1 1 1 0 0 00 3c 0
3 0 0 6 0 0 0 0 0 0 0 0 0 0 0 00 a5 0
3 1 0 6 0 0 0 0 0 1 0 1 0 0 0 00 ff 0
3 0 0 6 0 0 1 0 0 0 0 0 0 0 0 00 ff 0
4 0 1 7 0 1 0 0 0 0 0 0 0 0 0 00 00 0
4 0 1 7 0 1 0 0 0 0 0 0 0 0 0 00 00 0
4 0 1 7 0 2 0 0 0 0 0 0 0 0 0 40 01 0
4 0 1 7 0 0 0 0 0 0 0 0 0 0 0 00 20 0
4 0 1 7 0 3 0 0 0 0 0 0 0 0 0 00 20 0
4 0 1 7 0 0 0 0 0 0 0 0 0 0 0 00 00 0
5 0 1 7 1 0 0 0 0 0 0 0 0 0 0 b7 00 0
5 0 1 7 0 1 0 0 0 0 0 0 0 0 0 00 00 b
5 0 1 7 0 1 0 0 0 0 0 0 0 0 0 00 00 7
5 0 1 7 0 0 0 0 0 0 0 0 0 0 0 00 01 b
6 1 0 6 0 0 0 0 0 0 0 0 0 1 0 00 ff b
6 1 0 6 0 0 0 0 0 0 0 0 0 1 0 00 00 b
6 1 0 6 0 0 0 0 0 0 0 0 0 1 1 00 01 b
6 1 0 6 0 0 0 0 0 0 0 0 0 0 1 00 01 b
6 1 0 6 0 0 0 0 0 0 0 0 0 0 1 00 00 b
6 1 0 6 0 0 0 0 0 0 0 0 0 0 0 00 ff b
6 1 0 6 0 0 0 0 0 0 0 0 0 1 1 00 ff b
6 1 0 6 0 0 0 0 0 0 0 0 0 0 0 00 ff b

// File: files.f
up_pkg.sv
up_rb_if.sv
up_alu.sv
up_reg_block.sv
up_program_counter.sv
up_instruction_register.sv
up_stack_pointer.sv
up_datapath.sv
up_datapath_tb.sv

// File: Bender.yml
package:
  name: up_datapath

sources:
  - up_pkg.sv
  - up_rb_if.sv
  - up_alu.sv
  - up_reg_block.sv
  - up_program_counter.sv
  - up_instruction_register.sv
  - up_stack_pointer.sv
  - up_datapath.sv
  - target: test
    files:
      - up_datapath_tb.sv
